//--- verilog.f
+incdir+include
design/vec_pkg.sv
design/vec_decoder.sv
design/vec_ctrl_fsm.sv
design/vec_elem_counter.sv
design/vec_lane_align.sv
design/vec_regfile.sv
design/vec_coproc_top.sv
verification/tb_mem_model.sv
verification/tb_vec_coproc.sv

//--- Makefile
# Verilator build and run of the vector coprocessor testbench
SRCS := $(wildcard design/*.sv verification/*.sv include/*.svh)

obj_dir/Vtb_vec_coproc: verilog.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_vec_coproc -Mdir obj_dir -o Vtb_vec_coproc

run: obj_dir/Vtb_vec_coproc
	@out="$$(./obj_dir/Vtb_vec_coproc)"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- verification/tb_vec_coproc.sv
/* Directed tests of the PCPI vector coprocessor
   Issues one instruction per step, waits for pcpi_ready, checks vl and stored words */
`default_nettype none
`timescale 1ns/100ps
`include "vec_params.svh"

module tb_vec_coproc;
	import vec_pkg::*;

	localparam int TIMEOUT = 400; // Cycles allowed per instruction

	logic        clk;
	logic        rst_n;
	logic        pcpi_valid;
	logic [31:0] pcpi_insn;
	logic [31:0] pcpi_rs1;
	logic [31:0] pcpi_rs2;
	logic        pcpi_wr;
	logic        pcpi_wait;
	logic        pcpi_ready;
	logic [31:0] pcpi_rd;
	logic        mem_valid;
	logic        mem_ready;
	logic [31:0] mem_rdata;
	mem_req_t    mem_req;
	mem_req_t    held_req;  // Request seen while waiting for ready
	logic        pend;
	int          err_cnt;
	int          timeout_cnt;
	logic [31:0] last_rd;
	logic        last_wr;
	int          last_lat;  // Cycles from first valid cycle to ready
	logic [7:0]  exp_bytes [`VEC_VLENB]; // Register image expected by the next store
	logic [31:0] wr_addr_q [$];
	logic [31:0] wr_data_q [$];
	logic [3:0]  wr_strb_q [$];

	vec_coproc_top dut0 (
		.clk, .rst_n, .pcpi_valid, .pcpi_insn, .pcpi_rs1, .pcpi_rs2,
		.pcpi_wr, .pcpi_rd, .pcpi_wait, .pcpi_ready,
		.mem_valid, .mem_ready, .mem_rdata, .mem_req
	);

	tb_mem_model mem0 (.clk, .rst_n, .mem_valid, .mem_req, .mem_ready, .mem_rdata);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic log_error(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		err_cnt++;
	endtask

	// Bus watcher sampled mid-cycle
	always @(negedge clk) begin
		if (pend && (!mem_valid || mem_req != held_req))
			log_error("mem_valid or mem_req changed before mem_ready");
		pend     <= mem_valid && !mem_ready;
		held_req <= mem_req;
		if (mem_valid && mem_ready && |mem_req.wstrb) begin // Completed write beat
			wr_addr_q.push_back(mem_req.addr);
			wr_data_q.push_back(mem_req.wdata);
			wr_strb_q.push_back(mem_req.wstrb);
		end
	end

	// Byte of the memory pattern at address a
	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		logic [31:0] w;
		w = ((a >> 2) * 32'h01010101) ^ 32'h5a5a0000;
		return w[a[1:0]*8 +: 8];
	endfunction

	function automatic logic [31:0] enc_vsetvli(input logic [4:0] rs1f, input logic [10:0] zimm);
		return {1'b0, zimm, rs1f, 3'b111, 5'd10, 7'b1010111};
	endfunction

	function automatic logic [31:0] enc_vsetvl(input logic [4:0] rs1f, input logic [4:0] rs2f);
		return {7'b1000000, rs2f, rs1f, 3'b111, 5'd10, 7'b1010111};
	endfunction

	// mop 010 is strided and 000 is unit stride
	function automatic logic [31:0] enc_load(input logic [4:0] vd, input logic strided);
		return {3'b000, strided ? 3'b010 : 3'b000, 1'b1, strided ? 5'd12 : 5'd0, 5'd11,
			3'b000, vd, 7'b0000111};
	endfunction

	function automatic logic [31:0] enc_store(input logic [4:0] vs3);
		return {3'b000, 3'b000, 1'b1, 5'd0, 5'd11, 3'b000, vs3, 7'b0100111};
	endfunction

	task automatic run_insn(input logic [31:0] insn, input logic [31:0] rs1,
		input logic [31:0] rs2, input string name);
		int n;
		logic wait_lost; // pcpi_wait low while the host still waits
		n = 0;
		wait_lost = 1'b0;
		@(posedge clk);
		pcpi_insn  <= insn;
		pcpi_rs1   <= rs1;
		pcpi_rs2   <= rs2;
		pcpi_valid <= 1'b1;
		@(negedge clk); // First cycle with valid seen
		while (!pcpi_ready && n < TIMEOUT) begin
			if (n >= 2 && !pcpi_wait)
				wait_lost = 1'b1;
			@(negedge clk);
			n++;
		end
		if (!pcpi_ready) begin
			$display("Timeout: %s got no pcpi_ready within %0d cycles", name, TIMEOUT);
			timeout_cnt++;
		end
		if (wait_lost)
			log_error($sformatf("%s: pcpi_wait low before pcpi_ready", name));
		last_rd  = pcpi_rd;
		last_wr  = pcpi_wr;
		last_lat = n;
		@(posedge clk);
		pcpi_valid <= 1'b0;
		repeat (2) @(posedge clk); // Gap so the FSM is back in idle
	endtask

	task automatic set_vl(input logic [10:0] zimm, input logic [31:0] rs1,
		input logic [31:0] exp_vl, input string name);
		run_insn(enc_vsetvli(5'd11, zimm), rs1, 32'd0, name);
		if (!last_wr || last_rd !== exp_vl)
			log_error($sformatf("%s: pcpi_wr=%0b pcpi_rd=%0d, expected vl %0d",
				name, last_wr, last_rd, exp_vl));
		if (last_lat != 2)
			log_error($sformatf("%s: pcpi_ready after %0d cycles, expected 2", name, last_lat));
	endtask

	task automatic load_vec(input logic [4:0] vd, input logic [31:0] base,
		input logic [31:0] stride, input logic strided, input string name);
		run_insn(enc_load(vd, strided), base, stride, name);
		if (last_wr)
			log_error($sformatf("%s: pcpi_wr high on a load", name));
	endtask

	// Element i byte k sits at register byte i*nb+k
	task automatic expect_load(input logic [31:0] base, input logic [31:0] stride,
		input int nb, input int n);
		for (int i = 0; i < n; i++)
			for (int k = 0; k < nb; k++)
				exp_bytes[i*nb + k] = mem_byte(base + i*stride + k);
	endtask

	task automatic store_check(input logic [4:0] vs3, input logic [31:0] base,
		input int nbytes, input string name);
		int nw;
		logic [3:0] strb;
		logic [31:0] w;
		nw = (nbytes + 3) / 4;
		wr_addr_q.delete();
		wr_data_q.delete();
		wr_strb_q.delete();
		run_insn(enc_store(vs3), base, 32'd0, name);
		if (wr_addr_q.size() != nw)
			log_error($sformatf("%s: %0d words written, expected %0d", name,
				wr_addr_q.size(), nw));
		for (int j = 0; j < nw && j < wr_addr_q.size(); j++) begin
			for (int b = 0; b < 4; b++)
				strb[b] = (j*4 + b < nbytes); // Partial strobe only on the last word
			w = wr_data_q[j];
			if (wr_addr_q[j] !== base + 4*j || wr_strb_q[j] !== strb)
				log_error($sformatf("%s: word %0d addr %h strb %b, expected %h %b", name, j,
					wr_addr_q[j], wr_strb_q[j], base + 4*j, strb));
			for (int b = 0; b < 4; b++)
				if (strb[b] && w[b*8 +: 8] !== exp_bytes[j*4 + b])
					log_error($sformatf("%s: byte %0d is %h, expected %h", name, j*4 + b,
						w[b*8 +: 8], exp_bytes[j*4 + b]));
		end
	endtask

	task automatic test_vsetvli();
		set_vl(11'h008, 32'd100, 32'd4, "vsetvli e32 capped");
		set_vl(11'h008, 32'd3, 32'd3, "vsetvli e32 vl 3");
		run_insn(enc_vsetvli(5'd0, 11'h008), 32'd2, 32'd0, "vsetvli rs1 x0");
		if (!last_wr || last_rd !== 32'd3 || last_lat != 2)
			log_error($sformatf("vsetvli rs1 x0: rd=%0d wr=%0b lat=%0d, expected 3 1 2",
				last_rd, last_wr, last_lat));
	endtask

	task automatic test_vsetvl();
		run_insn(enc_vsetvl(5'd11, 5'd12), 32'd20, 32'd0, "vsetvl e8"); // vtype from rs2
		if (!last_wr || last_rd !== 32'd16 || last_lat != 2)
			log_error($sformatf("vsetvl e8: rd=%0d wr=%0b lat=%0d, expected 16 1 2",
				last_rd, last_wr, last_lat));
	endtask

	task automatic test_unit_e32();
		set_vl(11'h008, 32'd4, 32'd4, "unit e32 vl");
		load_vec(5'd1, 32'h1000, 32'd0, 1'b0, "unit load e32");
		expect_load(32'h1000, 32'd4, 4, 4);
		store_check(5'd1, 32'h2000, 16, "unit store e32");
	endtask

	task automatic test_strided(input logic [10:0] zimm, input int nb, input int vl,
		input logic [4:0] vd, input logic [31:0] base, input logic [31:0] stride,
		input logic [31:0] out, input string name);
		set_vl(zimm, vl, vl, name);
		load_vec(vd, base, stride, 1'b1, name);
		expect_load(base, stride, nb, vl);
		store_check(vd, out, vl*nb, name);
	endtask

	task automatic test_tail();
		set_vl(11'h008, 32'd4, 32'd4, "tail vl full");
		load_vec(5'd4, 32'h7000, 32'd0, 1'b0, "tail fill load");
		set_vl(11'h008, 32'd2, 32'd2, "tail vl short");
		load_vec(5'd4, 32'h8000, 32'd0, 1'b0, "tail short load");
		set_vl(11'h008, 32'd4, 32'd4, "tail vl back");
		expect_load(32'h7000, 32'd4, 4, 4);
		expect_load(32'h8000, 32'd4, 4, 2); // Lanes 2 and 3 keep the fill
		store_check(5'd4, 32'h9000, 16, "tail store");
	endtask

	task automatic test_non_vector();
		@(posedge clk);
		pcpi_insn  <= 32'h00a50513; // addi a0, a0, 10
		pcpi_valid <= 1'b1;
		repeat (20) begin
			@(negedge clk);
			if (pcpi_wait || pcpi_ready)
				log_error("non-vector instruction raised pcpi_wait or pcpi_ready");
		end
		@(posedge clk);
		pcpi_valid <= 1'b0;
	endtask

	initial begin
		pcpi_valid  = 1'b0;
		pcpi_insn   = 32'd0;
		pcpi_rs1    = 32'd0;
		pcpi_rs2    = 32'd0;
		rst_n       = 1'b0;
		pend        = 1'b0;
		err_cnt     = 0;
		timeout_cnt = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (pcpi_ready || pcpi_wait || pcpi_wr || mem_valid || pcpi_rd !== 32'd0)
			log_error("outputs not idle or vl not 0 after reset");
		test_vsetvli();
		test_vsetvl();
		test_unit_e32();
		test_strided(11'h000, 1, 10, 5'd2, 32'h3001, 32'd4, 32'h4000, "strided e8");
		test_strided(11'h004, 2, 5, 5'd3, 32'h5002, 32'd12, 32'h6000, "strided e16");
		test_tail();
		test_non_vector();
		$display("errors=%0d timeouts=%0d", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tb_mem_model.sv
/* Behavioral memory for the coprocessor testbench
   Random ready delays, pattern data for unwritten words, strobed writes */
`default_nettype none
`timescale 1ns/100ps

module tb_mem_model (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          mem_valid,
	input  vec_pkg::mem_req_t  mem_req,
	output logic               mem_ready,
	output logic [31:0]        mem_rdata
);
	import vec_pkg::*;

	logic [31:0] words [logic [29:0]]; // Only words that were written
	logic [31:0] lcg_state;
	logic [31:0] rnd;
	logic [1:0]  wait_cnt;             // Idle cycles left before ready

	// Classic 32-bit LCG constants
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] read_word(input logic [29:0] w);
		if (words.exists(w))
			return words[w];
		return ({2'b00, w} * 32'h01010101) ^ 32'h5a5a0000; // Any byte is computable
	endfunction

	function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				w[b*8 +: 8] = data[b*8 +: 8];
		end
		return w;
	endfunction

	assign rnd = lcg_next(lcg_state);

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lcg_state <= 32'h7b05;
			wait_cnt  <= 2'd0;
			mem_ready <= 1'b0;
			mem_rdata <= 32'd0;
		end else if (mem_valid && mem_ready) begin // Transfer completes on this edge
			if (|mem_req.wstrb)
				words[mem_req.addr[31:2]] = merge_word(read_word(mem_req.addr[31:2]),
					mem_req.wdata, mem_req.wstrb);
			mem_ready <= 1'b0;
			lcg_state <= rnd;
			wait_cnt  <= rnd[17:16]; // 0 to 3 wait cycles for the next beat
		end else if (mem_valid) begin
			if (wait_cnt == 2'd0) begin
				mem_ready <= 1'b1;
				mem_rdata <= read_word(mem_req.addr[31:2]);
			end else begin
				wait_cnt <= wait_cnt - 2'd1; // Back-pressure
			end
		end
	end

endmodule

`default_nettype wire

//--- design/vec_coproc_top.sv
/* PCPI vector coprocessor top, sits beside the scalar core
   Connects decoder, sequencer, counter, lane unit and register file */
`default_nettype none
`timescale 1ns/100ps
`include "vec_params.svh"

module vec_coproc_top (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          pcpi_valid,
	input  wire logic [31:0]   pcpi_insn,
	input  wire logic [31:0]   pcpi_rs1,
	input  wire logic [31:0]   pcpi_rs2,
	output logic               pcpi_wr,
	output logic [31:0]        pcpi_rd,
	output logic               pcpi_wait,
	output logic               pcpi_ready,
	output logic               mem_valid,
	input  wire logic          mem_ready,
	input  wire logic [31:0]   mem_rdata,
	output vec_pkg::mem_req_t  mem_req
);
	import vec_pkg::*;

	vec_insn_t              insn;
	logic                   cnt_start, cnt_step, cnt_last, store_mode;
	vl_t                    cnt_limit, cnt_idx, lane_vl;
	logic [31:0]            base, stride, cnt_addr;
	sew_e                   sew;
	vreg_addr_t             vreg_sel;
	logic [`VEC_VLENB-1:0]  wen_bytes;
	logic [`VEC_VLEN-1:0]   wdata;
	logic [31:0]            rd_word, st_wdata;
	logic [3:0]             st_wstrb;

	vec_decoder u_dec (
		.clk, .rst_n, .pcpi_valid, .pcpi_insn, .insn
	);

	vec_ctrl_fsm u_fsm (
		.clk, .rst_n, .pcpi_valid, .insn, .pcpi_rs1, .pcpi_rs2, .mem_ready,
		.idx(cnt_idx), .last(cnt_last),
		.pcpi_wr, .pcpi_rd, .pcpi_wait, .pcpi_ready, .mem_valid,
		.cnt_start, .cnt_step, .cnt_limit, .base, .stride,
		.sew, .vl(lane_vl), .vreg_sel, .store_mode
	);

	vec_elem_counter u_cnt (
		.clk, .rst_n, .start(cnt_start), .step(cnt_step), .limit(cnt_limit),
		.base, .stride, .idx(cnt_idx), .addr(cnt_addr), .last(cnt_last)
	);

	vec_lane_align u_lane (
		.sew, .idx(cnt_idx), .addr_lo(cnt_addr[1:0]), .mem_rdata, .rd_word,
		.vl(lane_vl), .store_mode, .wen_bytes, .wdata, .st_wdata, .st_wstrb
	);

	// Same register is source of stores and target of loads
	vec_regfile u_rf (
		.clk, .rst_n, .waddr(vreg_sel), .raddr(vreg_sel), .wen_bytes, .wdata,
		.word_sel(cnt_idx), .rd_word
	);

	assign mem_req.addr  = cnt_addr;
	assign mem_req.wdata = st_wdata;
	assign mem_req.wstrb = st_wstrb; // Zero on loads

endmodule

`default_nettype wire

//--- design/vec_regfile.sv
/* Vector register file, 32 entries of VLEN bits
   Byte-masked write port, one word read combinationally */
`default_nettype none
`timescale 1ns/100ps
`include "vec_params.svh"

module vec_regfile (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  vec_pkg::vreg_addr_t          waddr,
	input  vec_pkg::vreg_addr_t          raddr,
	input  wire logic [`VEC_VLENB-1:0]   wen_bytes,
	input  wire logic [`VEC_VLEN-1:0]    wdata,
	input  vec_pkg::vl_t                 word_sel,
	output logic [`VEC_XLEN-1:0]         rd_word
);
	import vec_pkg::*;

	logic [`VEC_VLEN-1:0] regs [`VEC_NREGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < `VEC_NREGS; r++)
				regs[r] <= '0; // All registers start cleared
		end else begin
			for (int b = 0; b < `VEC_VLENB; b++) begin
				if (wen_bytes[b])
					regs[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
			end
		end
	end

	// Word 0 holds the lowest lanes
	assign rd_word = regs[raddr][word_sel * `VEC_XLEN +: `VEC_XLEN];

endmodule

`default_nettype wire

//--- design/vec_lane_align.sv
/* Lane steering between memory words and vector register lanes
   Load side places one element, store side gives word data and strobes */
`default_nettype none
`timescale 1ns/100ps
`include "vec_params.svh"

module vec_lane_align (
	input  vec_pkg::sew_e                sew,
	input  vec_pkg::vl_t                 idx,
	input  wire logic [1:0]              addr_lo,
	input  wire logic [31:0]             mem_rdata,
	input  wire logic [31:0]             rd_word,
	input  vec_pkg::vl_t                 vl,
	input  wire logic                    store_mode,
	output logic [`VEC_VLENB-1:0]        wen_bytes,
	output logic [`VEC_VLEN-1:0]         wdata,
	output logic [31:0]                  st_wdata,
	output logic [3:0]                   st_wstrb
);
	import vec_pkg::*;

	logic [31:0] shifted;    // Element moved down to bit 0
	logic [31:0] elem;
	logic [3:0]  elem_mask;  // Bytes of one element
	logic [9:0]  lane_off;   // Byte offset of lane idx
	logic [9:0]  st_bytes;   // Active bytes of the register
	logic [9:0]  word_byte;
	logic        load_en;

	always_comb begin
		shifted = mem_rdata >> {addr_lo, 3'b000}; // Natural alignment assumed
		case (sew)
			SEW_8: begin
				elem      = {24'b0, shifted[7:0]};
				elem_mask = 4'b0001;
			end
			SEW_16: begin
				elem      = {16'b0, shifted[15:0]};
				elem_mask = 4'b0011;
			end
			default: begin
				elem      = shifted;
				elem_mask = 4'b1111;
			end
		endcase
		lane_off = {2'b00, idx} << sew;
		load_en  = !store_mode && (idx < vl) && (lane_off < `VEC_VLENB);
		wdata    = {{(`VEC_VLEN - 32){1'b0}}, elem} << {lane_off, 3'b000};
		// Only lane idx is enabled, the tail keeps its contents
		wen_bytes = load_en ?
			({{(`VEC_VLENB - 4){1'b0}}, elem_mask} << lane_off) : '0;
	end

	// Store word goes straight out, strobes trim the last partial word
	always_comb begin
		st_bytes = {2'b00, vl} << sew;
		for (int b = 0; b < 4; b++) begin
			word_byte   = {idx, 2'b00} + 10'(b);
			st_wstrb[b] = store_mode && (word_byte < st_bytes);
		end
		st_wdata = rd_word;
	end

endmodule

`default_nettype wire

//--- design/vec_elem_counter.sv
/* Element or word counter with a running memory address
   Loaded by start, advanced by step, flags the final beat */
`default_nettype none
`timescale 1ns/100ps

module vec_elem_counter (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        start,
	input  wire logic        step,
	input  vec_pkg::vl_t     limit,
	input  wire logic [31:0] base,
	input  wire logic [31:0] stride,
	output vec_pkg::vl_t     idx,
	output logic [31:0]      addr,
	output logic             last
);
	import vec_pkg::*;

	logic [31:0] addr_q; // Address of beat idx

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx    <= '0;
			addr_q <= '0;
		end else if (start) begin
			idx    <= '0;
			addr_q <= base;
		end else if (step) begin
			idx    <= idx + 1'b1;
			addr_q <= addr_q + stride; // Stride in bytes, 4 for stores
		end
	end

	assign addr = addr_q;
	assign last = (idx == limit - 1'b1); // Limit of zero never reaches here

endmodule

`default_nettype wire

//--- design/vec_ctrl_fsm.sv
/* Main sequencer of the coprocessor, holds vl and SEW
   Answers the PCPI host and walks the memory transfers of loads and stores */
`default_nettype none
`timescale 1ns/100ps
`include "vec_params.svh"

module vec_ctrl_fsm (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                pcpi_valid,
	input  vec_pkg::vec_insn_t       insn,
	input  wire logic [31:0]         pcpi_rs1,
	input  wire logic [31:0]         pcpi_rs2,
	input  wire logic                mem_ready,
	input  vec_pkg::vl_t             idx,
	input  wire logic                last,
	output logic                     pcpi_wr,
	output logic [31:0]              pcpi_rd,
	output logic                     pcpi_wait,
	output logic                     pcpi_ready,
	output logic                     mem_valid,
	output logic                     cnt_start,
	output logic                     cnt_step,
	output vec_pkg::vl_t             cnt_limit,
	output logic [31:0]              base,
	output logic [31:0]              stride,
	output vec_pkg::sew_e            sew,
	output vec_pkg::vl_t             vl,
	output vec_pkg::vreg_addr_t      vreg_sel,
	output logic                     store_mode
);
	import vec_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_CONFIG, S_XFER, S_GAP, S_DONE} state_e;

	state_e      state;
	vl_t         vl_q;      // vl CSR
	sew_e        sew_q;     // vtype CSR, only its SEW field is kept
	logic [10:0] vtype_src;
	sew_e        new_sew;
	vl_t         vlmax;
	vl_t         new_vl;
	logic [9:0]  st_bytes;  // Bytes covered by vl elements
	vl_t         st_words;  // Store beats, partial last word included
	logic        beat_done;

	always_comb begin
		vtype_src = (insn.op == OP_SETVL) ? pcpi_rs2[10:0] : insn.zimm;
		case (vtype_src[4:2]) // SEW = 8 << code
			3'd0:    new_sew = SEW_8;
			3'd1:    new_sew = SEW_16;
			default: new_sew = SEW_32;
		endcase
		vlmax = vl_t'(`VEC_VLENB >> new_sew);
		new_vl = (pcpi_rs1 > {24'b0, vlmax}) ? vlmax : pcpi_rs1[7:0]; // Capped at VLMAX
		st_bytes = {2'b00, vl_q} << sew_q;
		st_words = vl_t'((st_bytes + 10'd3) >> 2);
	end

	assign beat_done  = (state == S_XFER) && mem_ready;
	assign cnt_step   = beat_done;   // Counter advances on every completed beat
	assign mem_valid  = (state == S_XFER);
	assign pcpi_ready = (state == S_CONFIG) || (state == S_DONE);
	assign pcpi_wr    = (state == S_CONFIG);
	assign pcpi_wait  = (state != S_IDLE);
	assign pcpi_rd    = {24'b0, vl_q}; // New vl, CSR is updated entering CONFIG
	assign sew        = sew_q;

	// Element window of the lane unit
	// Stores see the whole vl, a load beat opens lanes up to the current idx
	assign vl = store_mode ? vl_q : (beat_done ? idx + 1'b1 : '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			vl_q       <= '0;
			sew_q      <= SEW_8;
			cnt_start  <= 1'b0;
			cnt_limit  <= '0;
			base       <= '0;
			stride     <= '0;
			vreg_sel   <= '0;
			store_mode <= 1'b0;
		end else begin
			cnt_start <= 1'b0; // Single-cycle pulse
			case (state)
				S_IDLE: begin
					if (pcpi_valid) begin
						case (insn.op)
							OP_SETVLI, OP_SETVL: begin
								sew_q <= new_sew;
								if (insn.rs1_nz)
									vl_q <= new_vl; // rs1 = x0 keeps the old vl
								state <= S_CONFIG;
							end
							OP_LOAD_UNIT, OP_LOAD_STRIDED: begin
								base       <= pcpi_rs1;
								// Unit stride steps one element
								stride     <= (insn.op == OP_LOAD_STRIDED) ? pcpi_rs2 :
									(32'd1 << sew_q);
								cnt_limit  <= vl_q; // One beat per element
								vreg_sel   <= insn.vd;
								store_mode <= 1'b0;
								cnt_start  <= 1'b1;
								state      <= S_GAP;
							end
							OP_STORE_UNIT: begin
								base       <= pcpi_rs1; // Word aligned
								stride     <= 32'd4;
								cnt_limit  <= st_words;
								vreg_sel   <= insn.vd;
								store_mode <= 1'b1;
								cnt_start  <= 1'b1;
								state      <= S_GAP;
							end
							default: state <= S_IDLE;
						endcase
					end
				end
				S_CONFIG: state <= S_IDLE;
				S_GAP: begin // mem_valid low between beats
					if (!pcpi_valid)
						state <= S_IDLE;
					else if (cnt_limit == '0)
						state <= S_DONE; // vl of zero, nothing to move
					else
						state <= S_XFER;
				end
				S_XFER: begin
					if (!pcpi_valid)
						state <= S_IDLE; // Host gave up
					else if (mem_ready)
						state <= last ? S_DONE : S_GAP;
				end
				S_DONE:  state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/vec_decoder.sv
/* Registers the PCPI instruction word and classifies it
   Output shows OP_NONE while pcpi_valid is low */
`default_nettype none
`timescale 1ns/100ps

module vec_decoder (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               pcpi_valid,
	input  wire logic [31:0]        pcpi_insn,
	output vec_pkg::vec_insn_t      insn
);
	import vec_pkg::*;

	vec_op_e op_d;
	logic [2:0] mop; // Addressing mode of loads and stores

	assign mop = pcpi_insn[28:26];

	always_comb begin
		op_d = OP_NONE;
		case (pcpi_insn[6:0])
			7'b0000111: begin // LOAD-FP major opcode
				if (mop == 3'b000 && pcpi_insn[24:20] == 5'd0)
					op_d = OP_LOAD_UNIT;
				else if (mop == 3'b010)
					op_d = OP_LOAD_STRIDED;
			end
			7'b0100111: begin // STORE-FP, unit stride only
				if (mop == 3'b000 && pcpi_insn[24:20] == 5'd0)
					op_d = OP_STORE_UNIT;
			end
			7'b1010111: begin // OP-V with funct3 OPCFG
				if (pcpi_insn[14:12] == 3'b111)
					op_d = pcpi_insn[31] ? OP_SETVL : OP_SETVLI;
			end
			default: op_d = OP_NONE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			insn <= '0;
		end else if (!pcpi_valid) begin
			insn <= '0; // Op field clears to NONE
		end else begin
			insn.op     <= op_d;
			insn.vd     <= pcpi_insn[11:7];
			insn.vs1    <= pcpi_insn[19:15];
			insn.rs1_nz <= |pcpi_insn[19:15];
			insn.zimm   <= pcpi_insn[30:20];
		end
	end

endmodule

`default_nettype wire

//--- design/vec_pkg.sv
/* Types shared by the vector coprocessor blocks
   Import inside a module body; port lists use scoped names */
`default_nettype none

package vec_pkg;

	// Decoded operation, NONE while the host has nothing for us
	typedef enum logic [2:0] {
		OP_NONE,
		OP_SETVLI,
		OP_SETVL,
		OP_LOAD_UNIT,
		OP_LOAD_STRIDED,
		OP_STORE_UNIT
	} vec_op_e;

	typedef logic [4:0] vreg_addr_t; // Vector register number
	typedef logic [7:0] vl_t;        // Element count, VLMAX is 16 at SEW 8

	// Registered result of the decoder
	typedef struct packed {
		vec_op_e     op;
		vreg_addr_t  vd;     // Destination, or store source
		vreg_addr_t  vs1;    // rs1 field as written in the instruction
		logic        rs1_nz; // rs1 field non-zero, vl is updated
		logic [10:0] zimm;   // vtype immediate of vsetvli
	} vec_insn_t;

	// Element width, vtype codes above 2 map to 32 bits
	typedef enum logic [1:0] {
		SEW_8,
		SEW_16,
		SEW_32
	} sew_e;

	// Memory request, a non-zero wstrb marks a write
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} mem_req_t;

endpackage

`default_nettype wire

//--- include/vec_params.svh
/* Sizing macros for the vector coprocessor
   Include wherever register, lane or memory word widths are needed */
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

// Bits per vector register
`define VEC_VLEN 128

// Architectural vector registers v0..v31
`define VEC_NREGS 32

// Scalar register and memory word width
`define VEC_XLEN 32

// Register width in bytes, one write enable per byte
`define VEC_VLENB (`VEC_VLEN / 8)

`endif
